// ==== src/trace_pkg.sv ====
package trace_pkg;

    // instruction class of a retired instruction
    typedef enum logic [3:0] {
        IT_BASE   = 4'd0,
        IT_MEXT   = 4'd1,
        IT_LOAD   = 4'd2,
        IT_STORE  = 4'd3,
        IT_BRANCH = 4'd4,
        IT_JAL    = 4'd5,
        IT_JALR   = 4'd6,
        IT_SYS    = 4'd7
    } itype_e;

    localparam int NUM_CLASSES = 8;

    // major opcode, bits [6:2] of a 32-bit word
    localparam logic [4:0] OP_LUI    = 5'b01101;
    localparam logic [4:0] OP_AUIPC  = 5'b00101;
    localparam logic [4:0] OP_JAL    = 5'b11011;
    localparam logic [4:0] OP_JALR   = 5'b11001;
    localparam logic [4:0] OP_BRANCH = 5'b11000;
    localparam logic [4:0] OP_LOAD   = 5'b00000;
    localparam logic [4:0] OP_STORE  = 5'b01000;
    localparam logic [4:0] OP_IMM    = 5'b00100;
    localparam logic [4:0] OP_REG    = 5'b01100;
    localparam logic [4:0] OP_FENCE  = 5'b00011;
    localparam logic [4:0] OP_SYSTEM = 5'b11100;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // low two bits of the word
    localparam logic [1:0] RVC_Q0        = 2'b00;
    localparam logic [1:0] RVC_Q1        = 2'b01;
    localparam logic [1:0] RVC_Q2        = 2'b10;
    localparam logic [1:0] RVC_QUAD_FULL = 2'b11;  // not compressed

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       rs1_used;
        logic       rs2_used;
    } source_s;

    typedef struct packed {
        logic [4:0] rd;
        logic       rd_used;
    } destination_s;

    typedef struct packed {
        source_s      source;
        destination_s dest;
        itype_e       itype;
        logic         is_compressed;
    } instr_info_s;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv32_word_s;

    typedef struct packed {
        logic [15:0] unused;  // next parcel, ignored
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  rd_rs1;
        logic [4:0]  rs2;
        logic [1:0]  quad;
    } rvc_word_s;

    typedef union packed {
        rv32_word_s rv32;
        rvc_word_s  rvc;
    } instr_word_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_word_u word;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
        instr_info_s info;
    } retire_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_word_u word;
        instr_info_s info;
        logic        dest_mismatch;
    } trace_s;

endpackage

// ==== src/rv32_decoder.sv ====
`timescale 1ns/1ns

module rv32_decoder import trace_pkg::*; (
    input  instr_word_u word_i,
    output instr_info_s info_o
);
    logic   rd_zero;
    logic   rs1_zero;
    logic   use_rs1;
    logic   use_rs2;
    logic   use_rd;
    itype_e itype;

    assign rd_zero  = (word_i.rv32.rd == REG_ZERO);
    assign rs1_zero = (word_i.rv32.rs1 == REG_ZERO);

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        itype   = IT_BASE;
        case (word_i.rv32.opcode[6:2])
            OP_LUI, OP_AUIPC: begin
                use_rd = 1'b1;
            end
            OP_JAL: begin
                use_rd = 1'b1;
                itype  = IT_JAL;
            end
            OP_JALR: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                itype   = IT_JALR;
            end
            OP_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                itype   = IT_BRANCH;
            end
            OP_LOAD: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                itype   = IT_LOAD;
            end
            OP_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                itype   = IT_STORE;
            end
            OP_IMM: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
                itype   = word_i.rv32.funct7[0] ? IT_MEXT : IT_BASE;  // muldiv
            end
            OP_FENCE: begin
                itype = IT_SYS;
            end
            OP_SYSTEM: begin
                itype = IT_SYS;
                // ecall, ebreak and mret touch no register
                if (!(rd_zero && rs1_zero)) begin
                    use_rs1 = !word_i.rv32.funct3[2];  // csr*i carries uimm in rs1
                    use_rd  = 1'b1;
                end
            end
            default: begin
                itype = IT_BASE;
            end
        endcase
    end

    // unused register fields read as x0
    always_comb begin
        info_o.source.rs1      = use_rs1 ? word_i.rv32.rs1 : REG_ZERO;
        info_o.source.rs2      = use_rs2 ? word_i.rv32.rs2 : REG_ZERO;
        info_o.source.rs1_used = use_rs1;
        info_o.source.rs2_used = use_rs2;
        info_o.dest.rd         = use_rd ? word_i.rv32.rd : REG_ZERO;
        info_o.dest.rd_used    = use_rd;
        info_o.itype           = itype;
        info_o.is_compressed   = 1'b0;
    end

endmodule

// ==== src/rvc_decoder.sv ====
`timescale 1ns/1ns

module rvc_decoder import trace_pkg::*; (
    input  instr_word_u word_i,
    output instr_info_s info_o
);
    logic [4:0] rs1_f;
    logic [4:0] rs2_f;
    logic [4:0] rs1_p;
    logic [4:0] rs2_p;
    logic       rs1_zero;
    logic       rs2_zero;
    logic       imm6_nz;
    logic       imm8_nz;

    assign rs1_f    = word_i.rvc.rd_rs1;
    assign rs2_f    = word_i.rvc.rs2;
    assign rs1_p    = {2'b01, rs1_f[2:0]};  // x8..x15
    assign rs2_p    = {2'b01, rs2_f[2:0]};
    assign rs1_zero = (rs1_f == REG_ZERO);
    assign rs2_zero = (rs2_f == REG_ZERO);
    assign imm6_nz  = word_i.rvc.b12 || !rs2_zero;
    assign imm8_nz  = word_i.rvc.b12 || !rs1_zero || (rs2_f[4:3] != 2'b00);  // bits 12:5

    function automatic instr_info_s mk_info(
        input logic [4:0] rs1,
        input logic       rs1_used,
        input logic [4:0] rs2,
        input logic       rs2_used,
        input logic [4:0] rd,
        input logic       rd_used,
        input itype_e     itype
    );
        instr_info_s info;
        info.source.rs1      = rs1;
        info.source.rs2      = rs2;
        info.source.rs1_used = rs1_used;
        info.source.rs2_used = rs2_used;
        info.dest.rd         = rd;
        info.dest.rd_used    = rd_used;
        info.itype           = itype;
        info.is_compressed   = 1'b1;
        return info;
    endfunction

    always_comb begin
        info_o = mk_info(REG_ZERO, 1'b0, REG_ZERO, 1'b0, REG_ZERO, 1'b0, IT_BASE);  // reserved
        case (word_i.rvc.quad)
            RVC_Q0: begin
                case (word_i.rvc.funct3)
                    3'd0: if (imm8_nz) info_o = mk_info(REG_SP, 1'b1, REG_ZERO, 1'b0, rs2_p, 1'b1, IT_BASE);
                    3'd2: info_o = mk_info(rs1_p, 1'b1, REG_ZERO, 1'b0, rs2_p, 1'b1, IT_LOAD);
                    3'd6: info_o = mk_info(rs1_p, 1'b1, rs2_p, 1'b1, REG_ZERO, 1'b0, IT_STORE);
                    default: ;
                endcase
            end
            RVC_Q1: begin
                case (word_i.rvc.funct3)
                    3'd0: info_o = mk_info(rs1_f, 1'b1, REG_ZERO, 1'b0, rs1_f, 1'b1, IT_BASE);
                    3'd1: info_o = mk_info(REG_ZERO, 1'b0, REG_ZERO, 1'b0, REG_RA, 1'b1, IT_JAL);
                    3'd2: info_o = mk_info(REG_ZERO, 1'b0, REG_ZERO, 1'b0, rs1_f, 1'b1, IT_BASE);
                    3'd3: begin
                        if (rs1_f == REG_SP && imm6_nz)  // c.addi16sp
                            info_o = mk_info(REG_SP, 1'b1, REG_ZERO, 1'b0, REG_SP, 1'b1, IT_BASE);
                        else if (rs1_f != REG_SP && imm6_nz)  // c.lui
                            info_o = mk_info(REG_ZERO, 1'b0, REG_ZERO, 1'b0, rs1_f, 1'b1, IT_BASE);
                    end
                    3'd4: begin
                        if (rs1_f[4:3] != 2'b11)  // srli, srai, andi
                            info_o = mk_info(rs1_p, 1'b1, REG_ZERO, 1'b0, rs1_p, 1'b1, IT_BASE);
                        else if (!word_i.rvc.b12)
                            info_o = mk_info(rs1_p, 1'b1, rs2_p, 1'b1, rs1_p, 1'b1, IT_BASE);
                    end
                    3'd5: info_o = mk_info(REG_ZERO, 1'b0, REG_ZERO, 1'b0, REG_ZERO, 1'b1, IT_JAL);
                    default: info_o = mk_info(rs1_p, 1'b1, REG_ZERO, 1'b0, REG_ZERO, 1'b0, IT_BRANCH);
                endcase
            end
            RVC_Q2: begin
                case (word_i.rvc.funct3)
                    3'd0: if (!word_i.rvc.b12) info_o = mk_info(rs1_f, 1'b1, REG_ZERO, 1'b0, rs1_f, 1'b1, IT_BASE);
                    3'd2: if (!rs1_zero) info_o = mk_info(REG_SP, 1'b1, REG_ZERO, 1'b0, rs1_f, 1'b1, IT_LOAD);
                    3'd4: begin
                        // mv/jr when bit 12 is clear, add/jalr/ebreak when set
                        if (!rs2_zero && !word_i.rvc.b12)
                            info_o = mk_info(REG_ZERO, 1'b0, rs2_f, 1'b1, rs1_f, 1'b1, IT_BASE);
                        else if (!rs2_zero)
                            info_o = mk_info(rs1_f, 1'b1, rs2_f, 1'b1, rs1_f, 1'b1, IT_BASE);
                        else if (!rs1_zero && !word_i.rvc.b12)
                            info_o = mk_info(rs1_f, 1'b1, REG_ZERO, 1'b0, REG_ZERO, 1'b1, IT_JALR);
                        else if (!rs1_zero)
                            info_o = mk_info(rs1_f, 1'b1, REG_ZERO, 1'b0, REG_RA, 1'b1, IT_JALR);
                        else if (word_i.rvc.b12)
                            info_o = mk_info(REG_ZERO, 1'b0, REG_ZERO, 1'b0, REG_ZERO, 1'b0, IT_SYS);
                    end
                    3'd6: info_o = mk_info(REG_SP, 1'b1, rs2_f, 1'b1, REG_ZERO, 1'b0, IT_STORE);
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== src/retire_decoder.sv ====
`timescale 1ns/1ns

module retire_decoder import trace_pkg::*; (
    input  logic        s_clk_i,
    input  logic        rst_n_i,
    input  logic        wb_valid_i,
    input  logic [31:0] wb_pc_i,
    input  logic [31:0] wb_instr_i,
    input  logic        rf_we_i,
    input  logic [4:0]  rf_waddr_i,
    input  logic [31:0] rf_wdata_i,
    output retire_s     dec_o
);
    instr_word_u word;
    instr_info_s info_rv32;
    instr_info_s info_rvc;
    instr_info_s info;

    assign word = wb_instr_i;

    rv32_decoder rv32_decoder_inst (
        .word_i (word),
        .info_o (info_rv32)
    );

    rvc_decoder rvc_decoder_inst (
        .word_i (word),
        .info_o (info_rvc)
    );

    assign info = (word.rvc.quad == RVC_QUAD_FULL) ? info_rv32 : info_rvc;

    always_ff @(posedge s_clk_i) begin
        dec_o.pc       <= wb_pc_i;
        dec_o.word     <= word;
        dec_o.rf_we    <= rf_we_i;
        dec_o.rf_waddr <= rf_waddr_i;
        dec_o.rf_wdata <= rf_wdata_i;
        dec_o.info     <= info;
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= wb_valid_i;
        end
    end

endmodule

// ==== src/dest_checker.sv ====
`timescale 1ns/1ns

module dest_checker import trace_pkg::*; (
    input  logic    s_clk_i,
    input  logic    rst_n_i,
    input  retire_s dec_i,
    output trace_s  trace_o,
    output logic    mismatch_o
);
    logic rd_expected;
    logic rd_missed;
    logic rd_extra;
    logic mismatch;

    // writes to x0 are never expected, so they are ignored on both sides
    assign rd_expected = dec_i.info.dest.rd_used && (dec_i.info.dest.rd != REG_ZERO);

    // no write, or the write went elsewhere
    assign rd_missed = rd_expected &&
                       (!dec_i.rf_we || (dec_i.rf_waddr != dec_i.info.dest.rd));

    // write from an instruction with no destination
    assign rd_extra = dec_i.rf_we && (dec_i.rf_waddr != REG_ZERO) &&
                      !dec_i.info.dest.rd_used;

    assign mismatch = dec_i.valid && (rd_missed || rd_extra);

    always_ff @(posedge s_clk_i) begin
        trace_o.pc            <= dec_i.pc;
        trace_o.word          <= dec_i.word;
        trace_o.info          <= dec_i.info;
        trace_o.dest_mismatch <= mismatch;
        if (!rst_n_i) begin
            trace_o.valid <= 1'b0;
            mismatch_o    <= 1'b0;
        end else begin
            trace_o.valid <= dec_i.valid;
            mismatch_o    <= mismatch;  // same cycle as trace valid
        end
    end

endmodule

// ==== src/retire_counters.sv ====
`timescale 1ns/1ns

module retire_counters import trace_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic                              s_clk_i,
    input  logic                              rst_n_i,
    input  retire_s                           dec_i,
    input  logic                              mismatch_i,
    output logic [CNT_W-1:0]                  cycle_cnt_o,
    output logic [CNT_W-1:0]                  retired_cnt_o,
    output logic [NUM_CLASSES-1:0][CNT_W-1:0] class_cnt_o,
    output logic [CNT_W-1:0]                  mismatch_cnt_o
);
    localparam int CLS_W = $clog2(NUM_CLASSES);

    logic             ret_valid_q;
    logic [CLS_W-1:0] ret_cls_q;

    // hold the retirement one cycle so it meets its mismatch pulse
    always_ff @(posedge s_clk_i) begin
        ret_cls_q <= CLS_W'(dec_i.info.itype);
        if (!rst_n_i) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= dec_i.valid;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            cycle_cnt_o    <= '0;
            retired_cnt_o  <= '0;
            class_cnt_o    <= '0;
            mismatch_cnt_o <= '0;
        end else begin
            cycle_cnt_o <= cycle_cnt_o + 1'b1;
            if (ret_valid_q) begin
                retired_cnt_o          <= retired_cnt_o + 1'b1;
                class_cnt_o[ret_cls_q] <= class_cnt_o[ret_cls_q] + 1'b1;
            end
            if (mismatch_i) begin
                mismatch_cnt_o <= mismatch_cnt_o + 1'b1;
            end
        end
    end

endmodule

// ==== src/retire_monitor_top.sv ====
`timescale 1ns/1ns

module retire_monitor_top import trace_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic                              s_clk_i,
    input  logic                              rst_n_i,
    input  logic                              wb_valid_i,
    input  logic [31:0]                       wb_pc_i,
    input  logic [31:0]                       wb_instr_i,
    input  logic                              rf_we_i,
    input  logic [4:0]                        rf_waddr_i,
    input  logic [31:0]                       rf_wdata_i,
    output trace_s                            trace_o,
    output logic [CNT_W-1:0]                  cycle_cnt_o,
    output logic [CNT_W-1:0]                  retired_cnt_o,
    output logic [NUM_CLASSES-1:0][CNT_W-1:0] class_cnt_o,
    output logic [CNT_W-1:0]                  mismatch_cnt_o
);
    retire_s dec;
    logic    mismatch;

    retire_decoder retire_decoder_inst (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .wb_valid_i (wb_valid_i),
        .wb_pc_i    (wb_pc_i),
        .wb_instr_i (wb_instr_i),
        .rf_we_i    (rf_we_i),
        .rf_waddr_i (rf_waddr_i),
        .rf_wdata_i (rf_wdata_i),
        .dec_o      (dec)
    );

    dest_checker dest_checker_inst (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec),
        .trace_o    (trace_o),
        .mismatch_o (mismatch)
    );

    retire_counters #(
        .CNT_W (CNT_W)
    ) retire_counters_inst (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .dec_i          (dec),
        .mismatch_i     (mismatch),
        .cycle_cnt_o    (cycle_cnt_o),
        .retired_cnt_o  (retired_cnt_o),
        .class_cnt_o    (class_cnt_o),
        .mismatch_cnt_o (mismatch_cnt_o)
    );

endmodule

// ==== dv/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// used bits are rs1, rs2, rd; a register that is not used reads as x0
function automatic instr_info_s pack_info(
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    input logic [4:0] rd,
    input logic [2:0] used,
    input itype_e     itype
);
    instr_info_s info;
    info.source.rs1_used = used[2];
    info.source.rs2_used = used[1];
    info.dest.rd_used    = used[0];
    info.source.rs1      = used[2] ? rs1 : 5'd0;
    info.source.rs2      = used[1] ? rs2 : 5'd0;
    info.dest.rd         = used[0] ? rd : 5'd0;
    info.itype           = itype;
    info.is_compressed   = 1'b0;
    return info;
endfunction

function automatic instr_info_s ref_rv32(input logic [31:0] w);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rd  = w[11:7];
    rs1 = w[19:15];
    rs2 = w[24:20];
    case (w[6:2])
        OP_LUI, OP_AUIPC: return pack_info(rs1, rs2, rd, 3'b001, IT_BASE);
        OP_JAL:    return pack_info(rs1, rs2, rd, 3'b001, IT_JAL);
        OP_JALR:   return pack_info(rs1, rs2, rd, 3'b101, IT_JALR);
        OP_BRANCH: return pack_info(rs1, rs2, rd, 3'b110, IT_BRANCH);
        OP_LOAD:   return pack_info(rs1, rs2, rd, 3'b101, IT_LOAD);
        OP_STORE:  return pack_info(rs1, rs2, rd, 3'b110, IT_STORE);
        OP_IMM:    return pack_info(rs1, rs2, rd, 3'b101, IT_BASE);
        OP_REG:    return pack_info(rs1, rs2, rd, 3'b111, w[25] ? IT_MEXT : IT_BASE);
        OP_FENCE:  return pack_info(rs1, rs2, rd, 3'b000, IT_SYS);
        OP_SYSTEM: begin
            if (rd == 5'd0 && rs1 == 5'd0)
                return pack_info(rs1, rs2, rd, 3'b000, IT_SYS);  // ecall, ebreak, mret
            return pack_info(rs1, rs2, rd, {!w[14], 2'b01}, IT_SYS);
        end
        default:   return pack_info(rs1, rs2, rd, 3'b000, IT_BASE);
    endcase
endfunction

function automatic instr_info_s ref_rvc(input logic [31:0] w);
    instr_info_s info;
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [4:0]  p1;
    logic [4:0]  p2;
    r1   = w[11:7];
    r2   = w[6:2];
    p1   = {2'b01, w[9:7]};
    p2   = {2'b01, w[4:2]};
    info = pack_info(5'd0, 5'd0, 5'd0, 3'b000, IT_BASE);  // reserved
    case ({w[1:0], w[15:13]})
        5'b00_000: if (w[12:5] != 8'd0) info = pack_info(REG_SP, 5'd0, p2, 3'b101, IT_BASE);
        5'b00_010: info = pack_info(p1, 5'd0, p2, 3'b101, IT_LOAD);
        5'b00_110: info = pack_info(p1, p2, 5'd0, 3'b110, IT_STORE);
        5'b01_000: info = pack_info(r1, 5'd0, r1, 3'b101, IT_BASE);
        5'b01_001: info = pack_info(5'd0, 5'd0, REG_RA, 3'b001, IT_JAL);
        5'b01_010: info = pack_info(5'd0, 5'd0, r1, 3'b001, IT_BASE);
        5'b01_011: begin
            if ({w[12], r2} != 6'd0 && r1 == REG_SP)
                info = pack_info(REG_SP, 5'd0, REG_SP, 3'b101, IT_BASE);
            else if ({w[12], r2} != 6'd0)
                info = pack_info(5'd0, 5'd0, r1, 3'b001, IT_BASE);
        end
        5'b01_100: begin
            if (w[11:10] != 2'b11)
                info = pack_info(p1, 5'd0, p1, 3'b101, IT_BASE);
            else if (!w[12])
                info = pack_info(p1, p2, p1, 3'b111, IT_BASE);
        end
        5'b01_101: info = pack_info(5'd0, 5'd0, 5'd0, 3'b001, IT_JAL);  // c.j links to x0
        5'b01_110, 5'b01_111: info = pack_info(p1, 5'd0, 5'd0, 3'b100, IT_BRANCH);
        5'b10_000: if (!w[12]) info = pack_info(r1, 5'd0, r1, 3'b101, IT_BASE);
        5'b10_010: if (r1 != 5'd0) info = pack_info(REG_SP, 5'd0, r1, 3'b101, IT_LOAD);
        5'b10_100: begin
            casez ({w[12], r1 != 5'd0, r2 != 5'd0})
                3'b0?1: info = pack_info(5'd0, r2, r1, 3'b011, IT_BASE);     // c.mv
                3'b1?1: info = pack_info(r1, r2, r1, 3'b111, IT_BASE);       // c.add
                3'b010: info = pack_info(r1, 5'd0, 5'd0, 3'b101, IT_JALR);   // c.jr
                3'b110: info = pack_info(r1, 5'd0, REG_RA, 3'b101, IT_JALR);
                3'b100: info = pack_info(5'd0, 5'd0, 5'd0, 3'b000, IT_SYS);  // c.ebreak
                default: ;
            endcase
        end
        5'b10_110: info = pack_info(REG_SP, r2, 5'd0, 3'b110, IT_STORE);
        default: ;
    endcase
    info.is_compressed = 1'b1;
    return info;
endfunction

function automatic instr_info_s ref_info(input logic [31:0] w);
    return (w[1:0] == 2'b11) ? ref_rv32(w) : ref_rvc(w);
endfunction

function automatic logic ref_mismatch(
    input instr_info_s info,
    input logic        we,
    input logic [4:0]  waddr
);
    if (info.dest.rd_used && info.dest.rd != 5'd0)
        return !we || waddr != info.dest.rd;
    return we && waddr != 5'd0 && !info.dest.rd_used;  // write to x0 counts as none
endfunction

`endif

// ==== dv/tb_retire_monitor.sv ====
`timescale 1ns/1ns

module tb_retire_monitor import trace_pkg::*; ();
    localparam int CNT_W  = 32;
    localparam int N_RV32 = 16;
    localparam int N_RVC  = 32;
    localparam int N_MIS  = 7;
    localparam int N_RAND = 200;
    // three cycles per rv32 word, two per rvc and mismatch entry, up to two per random one
    localparam int STIM_CYCLES = 20 + 3 * N_RV32 + 2 * N_RVC + 2 * N_MIS + 2 * N_RAND + 50;

    localparam logic [31:0] RV32_WORDS [N_RV32] = '{
        32'h000122b7, 32'h00000297, 32'h008000ef, 32'h00008067,  // lui auipc jal jalr
        32'h00208463, 32'h00022183, 32'h00532223, 32'h00100093,  // beq lw sw addi
        32'h002081b3, 32'h022081b3, 32'h0ff0000f, 32'h00000073,  // add mul fence ecall
        32'h300110f3, 32'h3002e1f3, 32'h30200073, 32'h0000005b   // csrrw csrrsi mret custom
    };
    localparam logic [31:0] RVC_WORDS [N_RVC] = '{
        32'h0040, 32'h0000, 32'h4104, 32'hc104, 32'h8000, 32'h2000, 32'h0001, 32'h0285,
        32'h2001, 32'h430d, 32'h6105, 32'h6385, 32'h6381, 32'h8005, 32'h8405, 32'h8885,
        32'h8c05, 32'h9c05, 32'ha001, 32'hc001, 32'he001, 32'h0286, 32'h4302, 32'h4002,
        32'h829a, 32'h929a, 32'h8082, 32'h9282, 32'h9002, 32'h8002, 32'hc01a, 32'h2002
    };
    // word, rf_we, rf_waddr
    localparam logic [37:0] MIS_VEC [N_MIS] = '{
        {32'h002081b3, 1'b1, 5'd3}, {32'h002081b3, 1'b0, 5'd0}, {32'h002081b3, 1'b1, 5'd4},
        {32'h00532223, 1'b1, 5'd5}, {32'h00208463, 1'b1, 5'd7}, {32'h00532223, 1'b1, 5'd0},
        {32'h00000013, 1'b0, 5'd0}
    };

    logic                              clk;
    logic                              rst_n;
    logic                              wb_valid;
    logic [31:0]                       wb_pc;
    logic [31:0]                       wb_instr;
    logic                              rf_we;
    logic [4:0]                        rf_waddr;
    logic [31:0]                       rf_wdata;
    trace_s                            trace;
    logic [CNT_W-1:0]                  cycle_cnt;
    logic [CNT_W-1:0]                  retired_cnt;
    logic [CNT_W-1:0]                  mismatch_cnt;
    logic [NUM_CLASSES-1:0][CNT_W-1:0] class_cnt;

    trace_s      exp_q[$];
    int          exp_edge_q[$];
    int          edge_cnt;
    int          exp_retired;
    int          exp_mismatch;
    int          exp_class[NUM_CLASSES];
    int          n_checks;
    int          n_errors;
    int          n_tests;
    logic [31:0] rng;

    `include "tb_ref_model.svh"

    retire_monitor_top #(
        .CNT_W (CNT_W)
    ) retire_monitor_top_inst (
        .s_clk_i        (clk),
        .rst_n_i        (rst_n),
        .wb_valid_i     (wb_valid),
        .wb_pc_i        (wb_pc),
        .wb_instr_i     (wb_instr),
        .rf_we_i        (rf_we),
        .rf_waddr_i     (rf_waddr),
        .rf_wdata_i     (rf_wdata),
        .trace_o        (trace),
        .cycle_cnt_o    (cycle_cnt),
        .retired_cnt_o  (retired_cnt),
        .class_cnt_o    (class_cnt),
        .mismatch_cnt_o (mismatch_cnt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic retire(input logic [31:0] word, input logic we, input logic [4:0] waddr);
        trace_s exp;
        rng      = xorshift32(rng);
        wb_valid = 1'b1;
        wb_instr = word;
        wb_pc    = wb_pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
        rf_we    = we;
        rf_waddr = waddr;
        rf_wdata = rng;
        exp.valid         = 1'b1;
        exp.pc            = wb_pc;
        exp.word          = word;
        exp.info          = ref_info(word);
        exp.dest_mismatch = ref_mismatch(exp.info, we, waddr);
        exp_q.push_back(exp);
        exp_edge_q.push_back(edge_cnt + 2);  // sampled next edge, traced one edge later
        @(negedge clk);
    endtask

    // the core writes exactly the decoded destination
    task automatic retire_agreed(input logic [31:0] word);
        instr_info_s info;
        info = ref_info(word);
        retire(word, info.dest.rd_used && info.dest.rd != 5'd0, info.dest.rd);
    endtask

    task automatic idle();
        wb_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic drain();
        wb_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
        for (int i = 0; i < NUM_CLASSES; i++)
            check($sformatf("class_cnt_o[%0d]", i), 64'(class_cnt[i]), 64'(exp_class[i]));
    endtask

    task automatic report(input string name, input int err_start);
        n_tests++;
        $display("test %-10s done, %0d errors", name, n_errors - err_start);
    endtask

    always @(negedge clk) begin
        trace_s exp;
        // counters update one edge after the trace record they belong to
        if (rst_n) begin
            check("retired_cnt_o", 64'(retired_cnt), 64'(exp_retired));
            check("mismatch_cnt_o", 64'(mismatch_cnt), 64'(exp_mismatch));
        end
        if (rst_n && trace.valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("trace record seen with no retirement outstanding at %0t", $time);
            end else begin
                exp = exp_q.pop_front();
                check("trace_o.valid edge", 64'(edge_cnt), 64'(exp_edge_q.pop_front()));
                check("trace_o.pc", 64'(trace.pc), 64'(exp.pc));
                check("trace_o.word", 64'(trace.word), 64'(exp.word));
                check("trace_o.info", 64'(trace.info), 64'(exp.info));
                check("trace_o.dest_mismatch", 64'(trace.dest_mismatch), 64'(exp.dest_mismatch));
                exp_retired++;
                exp_class[int'(exp.info.itype)]++;
                if (exp.dest_mismatch) exp_mismatch++;
            end
        end
    end

    initial begin
        #(STIM_CYCLES * 20 + 2000);
        $display("watchdog expired after %0d cycles, stimulus did not complete", STIM_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        int          err_start;
        int          mis_start;
        rst_n    = 1'b0;
        wb_valid = 1'b0;
        wb_pc    = 32'h8000_0000;
        wb_instr = 32'h0;
        rf_we    = 1'b0;
        rf_waddr = 5'd0;
        rf_wdata = 32'h0;
        rng      = 32'd17063;
        repeat (2) @(negedge clk);

        err_start = n_errors;
        check("trace_o.valid", 64'(trace.valid), 64'd0);
        check("cycle_cnt_o", 64'(cycle_cnt), 64'd0);
        check("retired_cnt_o", 64'(retired_cnt), 64'd0);
        check("mismatch_cnt_o", 64'(mismatch_cnt), 64'd0);
        for (int i = 0; i < NUM_CLASSES; i++)
            check($sformatf("class_cnt_o[%0d]", i), 64'(class_cnt[i]), 64'd0);
        rst_n = 1'b1;
        @(negedge clk);
        check("cycle_cnt_o", 64'(cycle_cnt), 64'd1);  // first clock out of reset
        repeat (5) @(negedge clk);
        check("cycle_cnt_o", 64'(cycle_cnt), 64'd6);
        report("reset", err_start);

        err_start = n_errors;
        for (int i = 0; i < N_RV32; i++) begin
            w = RV32_WORDS[i];
            retire_agreed(w);
            idle();
            rng = xorshift32(rng);
            retire_agreed({w[31:25], rng[4:0], rng[9:5], w[14:12], rng[14:10], w[6:0]});
        end
        drain();
        report("rv32", err_start);

        err_start = n_errors;
        for (int i = 0; i < N_RVC; i++) begin
            w = RVC_WORDS[i];
            retire_agreed(w);
            rng = xorshift32(rng);
            retire_agreed({rng[31:16], w[15:12], rng[9:0], w[1:0]});  // upper parcel ignored
        end
        drain();
        report("rvc", err_start);

        err_start = n_errors;
        mis_start = exp_mismatch;
        for (int i = 0; i < N_MIS; i++) begin
            retire(MIS_VEC[i][37:6], MIS_VEC[i][5], MIS_VEC[i][4:0]);
            idle();
        end
        drain();
        check("mismatch_cnt_o", 64'(mismatch_cnt), 64'(mis_start) + 64'd4);
        report("mismatch", err_start);

        err_start = n_errors;
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift32(rng);
            r   = rng;
            if (r[2:0] == 3'd0)
                w = xorshift32(r);
            else if (r[3])
                w = {RV32_WORDS[r[7:4]][31:25], r[31:22], RV32_WORDS[r[7:4]][14:12],
                     r[21:17], RV32_WORDS[r[7:4]][6:0]};
            else
                w = {r[31:16], RVC_WORDS[r[12:8]][15:12], r[21:12], RVC_WORDS[r[12:8]][1:0]};
            if (r[15:13] == 3'd0)
                retire(w, r[16], r[21:17]);  // arbitrary write
            else
                retire_agreed(w);
            if (r[23:22] == 2'd0) idle();
        end
        drain();
        report("stream", err_start);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+dv
src/trace_pkg.sv
src/rv32_decoder.sv
src/rvc_decoder.sv
src/retire_decoder.sv
src/dest_checker.sv
src/retire_counters.sv
src/retire_monitor_top.sv
dv/tb_retire_monitor.sv

// ==== Makefile ====
TOP  := tb_retire_monitor
SRCS := $(shell grep -v '^+' tb.f) dv/tb_ref_model.svh

obj_dir/V$(TOP): tb.f $(SRCS)
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
